// ==== core_pkg.sv ====
`default_nettype none

// Types shared along the load/store pipeline

package core_pkg;

    typedef logic [31:0] word_t;      // Load and store data
    typedef logic [31:0] addr_t;      // Byte address
    typedef logic [31:0] inst_num_t;  // Instruction sequence number
    typedef logic [7:0]  phy_tag_t;   // Destination physical register

endpackage

`default_nettype wire

// ==== lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    // Array geometry, 2**WORD_IDX_W words
    localparam int MEM_WORDS       = 256;
    localparam int WORD_IDX_W      = 8;
    localparam int RESET_WORD_BIAS = 3;   // Word i powers up as i + 3

    // RV32 funct3 width codes
    localparam logic [2:0] FUNCT3_LB  = 3'b000;  // Also SB
    localparam logic [2:0] FUNCT3_LH  = 3'b001;  // Also SH
    localparam logic [2:0] FUNCT3_LW  = 3'b010;  // Also SW
    localparam logic [2:0] FUNCT3_LBU = 3'b100;
    localparam logic [2:0] FUNCT3_LHU = 3'b101;

    typedef logic [WORD_IDX_W-1:0] word_idx_t;
    typedef logic [1:0]            byte_off_t;   // Byte within a word

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } acc_size_e;

endpackage

`default_nettype wire

// ==== ls_decode.sv ====
`default_nettype none

module ls_decode
    import core_pkg::*;
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       req_valid,
    input  logic       req_is_store,
    input  logic [2:0] req_funct3,
    input  addr_t      req_addr,
    input  word_t      req_store_data,
    input  inst_num_t  req_inst_num,
    input  phy_tag_t   req_phy_tag,
    output logic       s1_valid,
    output logic       s1_is_store,
    output logic       s1_fault,
    output logic       s1_signed,
    output acc_size_e  s1_size,
    output word_idx_t  s1_idx,
    output byte_off_t  s1_off,
    output addr_t      s1_addr,
    output word_t      s1_store_data,
    output inst_num_t  s1_inst_num,
    output phy_tag_t   s1_phy_tag
);

    acc_size_e dec_size;
    logic      dec_signed;
    logic      dec_bad_code;
    logic      dec_misaligned;
    byte_off_t req_off;

    assign req_off = req_addr[1:0];

    always_comb begin
        dec_size     = size_word;
        dec_signed   = 1'b1;
        dec_bad_code = 1'b0;
        case (req_funct3)
            FUNCT3_LB: dec_size = size_byte;
            FUNCT3_LH: dec_size = size_half;
            FUNCT3_LW: dec_size = size_word;
            FUNCT3_LBU: begin
                dec_size     = size_byte;
                dec_signed   = 1'b0;
                dec_bad_code = req_is_store;  // No unsigned store codes
            end
            FUNCT3_LHU: begin
                dec_size     = size_half;
                dec_signed   = 1'b0;
                dec_bad_code = req_is_store;
            end
            default: dec_bad_code = 1'b1;
        endcase
    end

    // Natural alignment required for half and word
    always_comb begin
        case (dec_size)
            size_half: dec_misaligned = req_off[0];
            size_word: dec_misaligned = (req_off != 2'b00);
            default:   dec_misaligned = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_is_store   <= req_is_store;
        s1_fault      <= dec_bad_code | dec_misaligned;
        s1_signed     <= dec_signed;
        s1_size       <= dec_size;
        s1_idx        <= req_addr[WORD_IDX_W+1:2];  // Upper bits wrap
        s1_off        <= req_off;
        s1_addr       <= req_addr;
        s1_store_data <= req_store_data;
        s1_inst_num   <= req_inst_num;
        s1_phy_tag    <= req_phy_tag;
    end

endmodule

`default_nettype wire

// ==== data_memory.sv ====
`default_nettype none

module data_memory
    import core_pkg::*;
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       s1_valid,
    input  logic       s1_is_store,
    input  logic       s1_fault,
    input  logic       s1_signed,
    input  acc_size_e  s1_size,
    input  word_idx_t  s1_idx,
    input  byte_off_t  s1_off,
    input  addr_t      s1_addr,
    input  word_t      s1_store_data,
    input  inst_num_t  s1_inst_num,
    input  phy_tag_t   s1_phy_tag,
    input  logic       commit_valid,
    input  logic [2:0] commit_funct3,
    input  addr_t      commit_addr,
    input  word_t      commit_data,
    output logic       s2_valid,
    output logic       s2_is_store,
    output logic       s2_fault,
    output logic       s2_signed,
    output acc_size_e  s2_size,
    output byte_off_t  s2_off,
    output addr_t      s2_addr,
    output inst_num_t  s2_inst_num,
    output phy_tag_t   s2_phy_tag,
    output word_t      s2_rdata
);

    word_t spec_mem   [MEM_WORDS];  // Written by executed stores
    word_t commit_mem [MEM_WORDS];  // Written by retiring stores only

    acc_size_e commit_size;
    word_idx_t commit_idx;
    logic      spec_wr;
    logic      spec_rd;

    // Places store data on its lanes and merges it into the old word
    function automatic word_t store_merge(word_t old, word_t data, acc_size_e size,
                                          byte_off_t off);
        word_t      lanes;
        logic [3:0] mask;
        word_t      merged;
        case (size)
            size_byte: begin
                lanes = {4{data[7:0]}};
                mask  = 4'b0001 << off;
            end
            size_half: begin
                lanes = {2{data[15:0]}};
                mask  = 4'b0011 << off;
            end
            default: begin
                lanes = data;
                mask  = 4'b1111;
            end
        endcase
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                merged[8*b +: 8] = lanes[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // Retiring stores already passed the alignment check
    always_comb begin
        case (commit_funct3)
            FUNCT3_LB: commit_size = size_byte;  // SB
            FUNCT3_LH: commit_size = size_half;  // SH
            default:   commit_size = size_word;
        endcase
    end

    assign commit_idx = commit_addr[WORD_IDX_W+1:2];
    assign spec_wr    = s1_valid & s1_is_store & ~s1_fault;
    assign spec_rd    = s1_valid & ~s1_is_store & ~s1_fault;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                commit_mem[i] <= word_t'(i + RESET_WORD_BIAS);
            end
        end else if (commit_valid && !flush) begin  // Commit dropped on exception
            commit_mem[commit_idx] <= store_merge(commit_mem[commit_idx], commit_data,
                                                  commit_size, commit_addr[1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                spec_mem[i] <= word_t'(i + RESET_WORD_BIAS);
            end
        end else if (flush) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                spec_mem[i] <= commit_mem[i];  // Roll back speculative state
            end
        end else if (spec_wr) begin
            spec_mem[s1_idx] <= store_merge(spec_mem[s1_idx], s1_store_data,
                                            s1_size, s1_off);
        end
    end

    always_ff @(posedge clk) begin
        if (spec_rd) begin
            s2_rdata <= spec_mem[s1_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_is_store <= s1_is_store;
        s2_fault    <= s1_fault;
        s2_signed   <= s1_signed;
        s2_size     <= s1_size;
        s2_off      <= s1_off;
        s2_addr     <= s1_addr;
        s2_inst_num <= s1_inst_num;
        s2_phy_tag  <= s1_phy_tag;
    end

endmodule

`default_nettype wire

// ==== load_result.sv ====
`default_nettype none

module load_result
    import core_pkg::*;
    import lsu_pkg::*;
(
    input  logic      s2_valid,
    input  logic      s2_is_store,
    input  logic      s2_fault,
    input  logic      s2_signed,
    input  acc_size_e s2_size,
    input  byte_off_t s2_off,
    input  addr_t     s2_addr,
    input  inst_num_t s2_inst_num,
    input  phy_tag_t  s2_phy_tag,
    input  word_t     s2_rdata,
    output logic      done,
    output logic      done_is_store,
    output logic      done_fault,
    output logic      done_wb,
    output word_t     done_data,
    output addr_t     done_addr,
    output inst_num_t done_inst_num,
    output phy_tag_t  done_phy_tag
);

    word_t lane_word;
    word_t ext_data;

    // Addressed lane moved down to bit 0
    assign lane_word = s2_rdata >> {s2_off, 3'b000};

    // Sign taken from the top bit of the selected lane
    always_comb begin
        case (s2_size)
            size_byte: ext_data = {{24{s2_signed & lane_word[7]}}, lane_word[7:0]};
            size_half: ext_data = {{16{s2_signed & lane_word[15]}}, lane_word[15:0]};
            default:   ext_data = s2_rdata;
        endcase
    end

    assign done          = s2_valid;
    assign done_is_store = s2_valid & s2_is_store;
    assign done_fault    = s2_valid & s2_fault;
    assign done_wb       = s2_valid & ~s2_is_store & ~s2_fault;  // Register file write
    assign done_data     = (s2_is_store || s2_fault) ? '0 : ext_data;
    assign done_addr     = s2_addr;
    assign done_inst_num = s2_inst_num;
    assign done_phy_tag  = s2_phy_tag;

endmodule

`default_nettype wire

// ==== load_store_unit.sv ====
`default_nettype none

module load_store_unit
    import core_pkg::*;
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  logic       req_is_store,
    input  logic [2:0] req_funct3,
    input  addr_t      req_addr,
    input  word_t      req_store_data,
    input  inst_num_t  req_inst_num,
    input  phy_tag_t   req_phy_tag,
    input  logic       commit_valid,
    input  logic [2:0] commit_funct3,
    input  addr_t      commit_addr,
    input  word_t      commit_data,
    input  logic       exception,
    output logic       done,
    output logic       done_is_store,
    output logic       done_fault,
    output logic       done_wb,
    output word_t      done_data,
    output addr_t      done_addr,
    output inst_num_t  done_inst_num,
    output phy_tag_t   done_phy_tag
);

    // Decode to memory stage
    logic      s1_valid;
    logic      s1_is_store;
    logic      s1_fault;
    logic      s1_signed;
    acc_size_e s1_size;
    word_idx_t s1_idx;
    byte_off_t s1_off;
    addr_t     s1_addr;
    word_t     s1_store_data;
    inst_num_t s1_inst_num;
    phy_tag_t  s1_phy_tag;

    // Memory stage to load result
    logic      s2_valid;
    logic      s2_is_store;
    logic      s2_fault;
    logic      s2_signed;
    acc_size_e s2_size;
    byte_off_t s2_off;
    addr_t     s2_addr;
    inst_num_t s2_inst_num;
    phy_tag_t  s2_phy_tag;
    word_t     s2_rdata;

    ls_decode i_ls_decode (.flush(exception), .*);

    data_memory i_data_memory (.flush(exception), .*);  // Restore on exception

    load_result i_load_result (.*);

endmodule

`default_nettype wire

// ==== tb_load_store_unit.sv ====
`default_nettype none

module tb_load_store_unit
    import core_pkg::*;
    import lsu_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk = 1'b0;
    logic reset;
    logic req_valid, req_is_store, commit_valid, exception;
    logic [2:0] req_funct3, commit_funct3;
    addr_t req_addr, commit_addr;
    word_t req_store_data, commit_data;
    inst_num_t req_inst_num;
    phy_tag_t req_phy_tag;
    logic done, done_is_store, done_fault, done_wb;
    word_t done_data;
    addr_t done_addr;
    inst_num_t done_inst_num;
    phy_tag_t done_phy_tag;

    word_t ref_spec [MEM_WORDS];    // Model of the speculative array
    word_t ref_commit [MEM_WORDS];  // Model of the committed array
    logic [31:0] lcg_state = 32'd48210;
    inst_num_t inst_cnt = 0;
    logic q_store[$], q_fault[$];   // Expected completions, oldest first
    word_t q_data[$];
    addr_t q_addr[$];
    inst_num_t q_inst[$];

    load_store_unit i_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic access_fault(logic st, logic [2:0] f3, logic [1:0] off);
        if (f3 == 3'd2) return off != 2'd0;
        if (f3 == 3'd1 || (f3 == 3'd5 && !st)) return off[0];
        return !(f3 == 3'd0 || (f3 == 3'd4 && !st));
    endfunction

    function automatic word_t merge_store(word_t old, word_t d, logic [2:0] f3,
                                          logic [1:0] off);
        word_t w;
        w = old;
        if (f3 == 3'd0) w[8*off +: 8] = d[7:0];
        else if (f3 == 3'd1) w[8*off +: 16] = d[15:0];
        else w = d;
        return w;
    endfunction

    function automatic word_t load_value(word_t w, logic [2:0] f3, logic [1:0] off);
        word_t s;
        s = w >> (8 * off);
        case (f3)
            3'd0: return {{24{s[7]}}, s[7:0]};
            3'd1: return {{16{s[15]}}, s[15:0]};
            3'd4: return {24'h0, s[7:0]};
            3'd5: return {16'h0, s[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // Drives one request and records what it must return
    task automatic issue(logic st, logic [2:0] f3, addr_t a, word_t d);
        logic flt;
        int idx;
        flt = access_fault(st, f3, a[1:0]);
        idx = a[WORD_IDX_W+1:2];
        req_valid = 1'b1;
        req_is_store = st;
        req_funct3 = f3;
        req_addr = a;
        req_store_data = d;
        req_inst_num = inst_cnt;
        req_phy_tag = inst_cnt[7:0] ^ 8'h5a;
        inst_cnt++;
        q_store.push_back(st);
        q_fault.push_back(flt);
        q_addr.push_back(a);
        q_inst.push_back(req_inst_num);
        q_data.push_back((st || flt) ? 32'h0 : load_value(ref_spec[idx], f3, a[1:0]));
        if (st && !flt) ref_spec[idx] = merge_store(ref_spec[idx], d, f3, a[1:0]);
    endtask

    task automatic check_done(string name);
        logic exp_store;
        logic exp_fault;
        inst_num_t exp_inst;
        exp_store = q_store.pop_front();
        exp_fault = q_fault.pop_front();
        exp_inst = q_inst.pop_front();
        check({name, " is_store"}, exp_store, done_is_store);
        check({name, " fault"}, exp_fault, done_fault);
        check({name, " wb"}, !exp_store && !exp_fault, done_wb);
        check({name, " data"}, q_data.pop_front(), done_data);
        check({name, " addr"}, q_addr.pop_front(), done_addr);
        check({name, " inst_num"}, exp_inst, done_inst_num);
        check({name, " phy_tag"}, exp_inst[7:0] ^ 8'h5a, done_phy_tag);
    endtask

    task automatic run_one(string name, logic st, logic [2:0] f3, addr_t a, word_t d);
        int edges;
        issue(st, f3, a, d);
        @(posedge clk);
        #2 req_valid = 1'b0;
        edges = 1;  // The edge that samples the request
        while (!done && edges < 20) begin
            @(posedge clk);
            #2 edges++;
        end
        if (!done) begin
            $display("%s: done never came", name);
            $display("TB FAILED");
            $fatal(1);
        end
        check({name, " latency"}, 2, edges);
        check_done(name);
    endtask

    task automatic commit_store(logic [2:0] f3, addr_t a, word_t d);
        int idx;
        idx = a[WORD_IDX_W+1:2];
        commit_valid = 1'b1;
        commit_funct3 = f3;
        commit_addr = a;
        commit_data = d;
        ref_commit[idx] = merge_store(ref_commit[idx], d, f3, a[1:0]);
        @(posedge clk);
        #2 commit_valid = 1'b0;
    endtask

    task automatic read_reset_contents();
        for (int i = 0; i < 6; i++) begin
            run_one("reset_contents", 1'b0, 3'd2, addr_t'((i * 37 % MEM_WORDS) * 4), 0);
        end
    endtask

    task automatic load_all_widths();
        addr_t base;
        for (int n = 0; n < 4; n++) begin
            base = {lcg_next() & 32'h3fc};
            // Lanes of both signs, bit 31 unlike some lane's top bit
            run_one("load_widths sw", 1'b1, 3'd2, base,
                    (lcg_next() & 32'h7f7f_7f7f) |
                    ((n % 2 == 1) ? 32'h8000_8080 : 32'h0080_8000));
            for (int off = 0; off < 4; off++) begin
                run_one("load_widths lb", 1'b0, 3'd0, base + off, 0);
                run_one("load_widths lbu", 1'b0, 3'd4, base + off, 0);
            end
            for (int off = 0; off < 4; off += 2) begin
                run_one("load_widths lh", 1'b0, 3'd1, base + off, 0);
                run_one("load_widths lhu", 1'b0, 3'd5, base + off, 0);
            end
        end
    endtask

    task automatic merge_stores();
        run_one("store_merge sw", 1'b1, 3'd2, 32'h100, 32'h1122_3344);
        run_one("store_merge sb", 1'b1, 3'd0, 32'h103, 32'hffff_ffaa);
        run_one("store_merge sh", 1'b1, 3'd1, 32'h100, 32'h0000_beef);
        run_one("store_merge lw", 1'b0, 3'd2, 32'h100, 0);
        run_one("store_merge sb1", 1'b1, 3'd0, 32'h101, 32'h77);
        run_one("store_merge lw2", 1'b0, 3'd2, 32'h100, 0);
    endtask

    task automatic raise_faults();
        run_one("faults lh", 1'b0, 3'd1, 32'h205, 0);
        run_one("faults lw", 1'b0, 3'd2, 32'h202, 0);
        run_one("faults funct3", 1'b0, 3'd3, 32'h200, 0);
        run_one("faults sw_mis", 1'b1, 3'd2, 32'h201, 32'hdead_beef);
        run_one("faults store4", 1'b1, 3'd4, 32'h200, 32'hdead_beef);
        run_one("faults lw after", 1'b0, 3'd2, 32'h200, 0);
    endtask

    task automatic commit_and_restore();
        int cnt;
        run_one("restore st0", 1'b1, 3'd2, 32'h300, 32'haaaa_0001);
        run_one("restore st1", 1'b1, 3'd1, 32'h306, 32'h0000_5555);
        run_one("restore st2", 1'b1, 3'd2, 32'h308, 32'hcccc_0003);
        commit_store(3'd2, 32'h300, 32'haaaa_0001);
        commit_store(3'd1, 32'h306, 32'h0000_5555);
        issue(1'b1, 3'd2, 32'h30c, 32'h1234_5678);  // Flushed before completion
        void'(q_store.pop_back());
        void'(q_fault.pop_back());
        void'(q_data.pop_back());
        void'(q_addr.pop_back());
        void'(q_inst.pop_back());
        @(posedge clk);
        #2 req_valid = 1'b0;
        exception = 1'b1;
        commit_valid = 1'b1;  // Commit in the exception cycle is dropped
        commit_funct3 = 3'd2;
        commit_addr = 32'h308;
        commit_data = 32'hcccc_0003;
        @(posedge clk);
        #2 exception = 1'b0;
        commit_valid = 1'b0;
        ref_spec = ref_commit;
        cnt = 0;
        while (cnt < 20) begin
            if (done) begin
                $display("restore: done came for a request flushed by the exception");
                $display("TB FAILED");
                $fatal(1);
            end
            @(posedge clk);
            #2 cnt++;
        end
        for (int a = 32'h300; a < 32'h310; a += 4) begin
            run_one("restore lw", 1'b0, 3'd2, a, 0);
        end
    endtask

    task automatic stream_back_to_back();
        logic [31:0] r;
        for (int i = 0; i < 24; i++) begin
            if (i < 16) begin
                r = lcg_next();
                issue(r[0], r[1] ? 3'd2 : (r[0] ? 3'd0 : 3'd4),
                      {22'h0, r[9:2], (r[1] ? 2'b00 : r[11:10])}, lcg_next());
            end else begin
                req_valid = 1'b0;
            end
            @(posedge clk);
            #2 if (done) check_done("stream");
        end
        check("stream drained", 0, q_inst.size());
    endtask

    initial begin
        reset = 1'b1;
        req_valid = 1'b0;
        req_is_store = 1'b0;
        req_funct3 = 3'd0;
        req_addr = '0;
        req_store_data = '0;
        req_inst_num = '0;
        req_phy_tag = '0;
        commit_valid = 1'b0;
        commit_funct3 = 3'd0;
        commit_addr = '0;
        commit_data = '0;
        exception = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_spec[i] = i + RESET_WORD_BIAS;
            ref_commit[i] = i + RESET_WORD_BIAS;
        end
        repeat (4) @(posedge clk);
        #2 reset = 1'b0;
        check("reset done", 0, done);
        check("reset wb", 0, done_wb);
        read_reset_contents();
        load_all_widths();
        merge_stores();
        raise_faults();
        commit_and_restore();
        stream_back_to_back();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
core_pkg.sv
lsu_pkg.sv
ls_decode.sv
data_memory.sv
load_result.sv
load_store_unit.sv
tb_load_store_unit.sv
